/* src/spm_consts.svh */
// Scratchpad memory constants
`ifndef SPM_CONSTS_SVH
`define SPM_CONSTS_SVH

// Bank word width and byte strobe count
`define SPM_DATA_W 32
`define SPM_STRB_W (`SPM_DATA_W / 8)

// Bank count and bank index width
`define SPM_NUM_BANKS 4
`define SPM_BANK_W 2

// Rows per bank and row index width
`define SPM_ROWS 256
`define SPM_ROW_W 8

// Word address covers every bank and row
`define SPM_ADDR_W (`SPM_BANK_W + `SPM_ROW_W)

`define SPM_CNT_W 16
`define SPM_CFG_ADDR_W 3

`endif

/* src/spm_pkg.sv */
// Scratchpad memory types
`include "spm_consts.svh"

package spm_pkg;

  // Address mapping mode held in config register 0
  typedef enum logic {
    MAP_INTERLEAVED = 1'b0,
    MAP_CONTIGUOUS  = 1'b1
  } map_mode_e;

  // Interleaved view
  // consecutive words rotate through the banks
  typedef struct packed {
    logic [`SPM_ROW_W-1:0]  row;
    logic [`SPM_BANK_W-1:0] bank;
  } addr_il_t;

  // Contiguous view
  // each bank owns one block of rows
  typedef struct packed {
    logic [`SPM_BANK_W-1:0] bank;
    logic [`SPM_ROW_W-1:0]  row;
  } addr_ct_t;

  // One word address read through the view the mode selects
  typedef union packed {
    addr_il_t il;
    addr_ct_t ct;
  } spm_addr_u;

endpackage

/* src/spm_bank_if.sv */
// SRAM bank interface
`include "spm_consts.svh"

interface spm_bank_if;

  // Single-cycle request strobe
  logic                   req;
  logic                   we;
  logic [`SPM_ROW_W-1:0]  row;
  logic [`SPM_DATA_W-1:0] wdata;
  logic [`SPM_STRB_W-1:0] be;

  // Registered read data that is valid the cycle after a read
  logic [`SPM_DATA_W-1:0] rdata;

  // Request side driven by the address mapper
  modport master (
    output req, we, row, wdata, be,
    input  rdata
  );

  // Memory side
  modport slave (
    input  req, we, row, wdata, be,
    output rdata
  );

endinterface

/* src/spm_stat_if.sv */
// Mapper to config block link
`include "spm_consts.svh"

interface spm_stat_if;

  spm_pkg::map_mode_e      mode;
  logic                    stall;

  // One report per accepted memory request
  logic                    acc_valid;
  logic [`SPM_BANK_W-1:0]  acc_bank;

  modport regs (
    output mode, stall,
    input  acc_valid, acc_bank
  );

  modport mapper (
    input  mode, stall,
    output acc_valid, acc_bank
  );

endinterface

/* src/sram.sv */
// Behavioural SRAM bank
`include "spm_consts.svh"

module sram (
  input  logic      clk_i,
  input  logic      rst_n_i,
  spm_bank_if.slave bank
);

  logic [`SPM_DATA_W-1:0] mem [`SPM_ROWS];

  // Write only the bytes whose strobe is set
  always_ff @(posedge clk_i) begin
    if (bank.req && bank.we) begin
      for (int i = 0; i < `SPM_STRB_W; i++) begin
        if (bank.be[i]) begin
          mem[bank.row][i*8 +: 8] <= bank.wdata[i*8 +: 8];
        end
      end
    end
  end

  // Output register loads on a read and holds through writes and idle cycles
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bank.rdata <= '0;
    end else if (bank.req && !bank.we) begin
      bank.rdata <= mem[bank.row];
    end
  end

endmodule

/* src/spm_addr_map.sv */
// Scratchpad request front end
`include "spm_consts.svh"

module spm_addr_map (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  // Request port
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  logic                   req_we_i,
  input  spm_pkg::spm_addr_u     req_addr_i,
  input  logic [`SPM_DATA_W-1:0] req_wdata_i,
  input  logic [`SPM_STRB_W-1:0] req_be_i,

  // Response port with a fixed latency of one cycle
  output logic                   rsp_valid_o,
  output logic [`SPM_DATA_W-1:0] rsp_rdata_o,

  spm_bank_if.master             bank [`SPM_NUM_BANKS],
  spm_stat_if.mapper             stat
);

  logic                   accept;
  logic [`SPM_BANK_W-1:0] sel_bank;
  logic [`SPM_ROW_W-1:0]  sel_row;

  // Response pipeline
  logic                   rsp_valid_q;
  logic                   rsp_rd_q;
  logic [`SPM_BANK_W-1:0] rsp_bank_q;

  logic [`SPM_DATA_W-1:0] bank_rdata [`SPM_NUM_BANKS];

  // No request is taken in the cycle the mode changes
  assign req_ready_o = !stat.stall;
  assign accept      = req_valid_i && req_ready_o;

  // Pick the address view that the current mode names
  always_comb begin
    if (stat.mode == spm_pkg::MAP_CONTIGUOUS) begin
      sel_bank = req_addr_i.ct.bank;
      sel_row  = req_addr_i.ct.row;
    end else begin
      sel_bank = req_addr_i.il.bank;
      sel_row  = req_addr_i.il.row;
    end
  end

  // Only the selected bank sees req while the rest of the request fans out
  for (genvar b = 0; b < `SPM_NUM_BANKS; b++) begin : gen_bank
    assign bank[b].req   = accept && (sel_bank == `SPM_BANK_W'(b));
    assign bank[b].we    = req_we_i;
    assign bank[b].row   = sel_row;
    assign bank[b].wdata = req_wdata_i;
    assign bank[b].be    = req_be_i;

    // Flatten so the read mux can index by a variable
    assign bank_rdata[b] = bank[b].rdata;
  end

  // Access report that the config block counts at the next edge
  assign stat.acc_valid = accept;
  assign stat.acc_bank  = sel_bank;

  // Captured on the same edge as the bank request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
      rsp_rd_q    <= 1'b0;
      rsp_bank_q  <= '0;
    end else begin
      rsp_valid_q <= accept;
      if (accept) begin
        rsp_rd_q   <= !req_we_i;
        rsp_bank_q <= sel_bank;
      end
    end
  end

  assign rsp_valid_o = rsp_valid_q;

  // Write responses carry zero
  assign rsp_rdata_o = (rsp_valid_q && rsp_rd_q) ? bank_rdata[rsp_bank_q] : '0;

endmodule

/* src/spm_cfg_regs.sv */
// Scratchpad configuration registers
`include "spm_consts.svh"

module spm_cfg_regs (
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  input  logic                       cfg_valid_i,
  input  logic                       cfg_we_i,
  input  logic [`SPM_CFG_ADDR_W-1:0] cfg_addr_i,
  input  logic [`SPM_DATA_W-1:0]     cfg_wdata_i,
  output logic [`SPM_DATA_W-1:0]     cfg_rdata_o,

  spm_stat_if.regs                   stat
);

  logic                       cfg_wr;
  logic                       mode_wr;
  spm_pkg::map_mode_e         mode_q;
  logic                       stall_q;
  logic [`SPM_NUM_BANKS-1:0]  cnt_clr;
  logic [`SPM_NUM_BANKS-1:0]  cnt_inc;
  logic [`SPM_CNT_W-1:0]      cnt_q [`SPM_NUM_BANKS];

  assign cfg_wr  = cfg_valid_i && cfg_we_i;
  assign mode_wr = cfg_wr && (cfg_addr_i == '0);

  // Stall lasts the single cycle in which the new mode applies
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mode_q  <= spm_pkg::MAP_INTERLEAVED;
      stall_q <= 1'b0;
    end else begin
      stall_q <= mode_wr;
      if (mode_wr) begin
        mode_q <= spm_pkg::map_mode_e'(cfg_wdata_i[0]);
      end
    end
  end

  assign stat.mode  = mode_q;
  assign stat.stall = stall_q;

  // Counters sit at addresses 1 to 4
  for (genvar b = 0; b < `SPM_NUM_BANKS; b++) begin : gen_cnt_ctl
    assign cnt_clr[b] = cfg_wr && (cfg_addr_i == `SPM_CFG_ADDR_W'(b + 1));
    assign cnt_inc[b] = stat.acc_valid && (stat.acc_bank == `SPM_BANK_W'(b));
  end

  // Clear wins over a same-cycle increment; count saturates at all ones
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int b = 0; b < `SPM_NUM_BANKS; b++) begin
        cnt_q[b] <= '0;
      end
    end else begin
      for (int b = 0; b < `SPM_NUM_BANKS; b++) begin
        if (cnt_clr[b]) begin
          cnt_q[b] <= '0;
        end else if (cnt_inc[b] && (cnt_q[b] != '1)) begin
          cnt_q[b] <= cnt_q[b] + 1'b1;
        end
      end
    end
  end

  // Read mux with zero for unmapped addresses
  always_comb begin
    cfg_rdata_o = '0;
    if (cfg_addr_i == '0) begin
      cfg_rdata_o[0] = mode_q;
    end
    for (int b = 0; b < `SPM_NUM_BANKS; b++) begin
      if (cfg_addr_i == `SPM_CFG_ADDR_W'(b + 1)) begin
        cfg_rdata_o[`SPM_CNT_W-1:0] = cnt_q[b];
      end
    end
  end

endmodule

/* src/spm_top.sv */
// Banked scratchpad memory top
`include "spm_consts.svh"

module spm_top (
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  // Memory request port
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  logic                       req_we_i,
  input  logic [`SPM_ADDR_W-1:0]     req_addr_i,
  input  logic [`SPM_DATA_W-1:0]     req_wdata_i,
  input  logic [`SPM_STRB_W-1:0]     req_be_i,

  // Memory response port
  output logic                       rsp_valid_o,
  output logic [`SPM_DATA_W-1:0]     rsp_rdata_o,

  // Configuration port that is always ready
  input  logic                       cfg_valid_i,
  input  logic                       cfg_we_i,
  input  logic [`SPM_CFG_ADDR_W-1:0] cfg_addr_i,
  input  logic [`SPM_DATA_W-1:0]     cfg_wdata_i,
  output logic [`SPM_DATA_W-1:0]     cfg_rdata_o
);

  spm_bank_if bank_if [`SPM_NUM_BANKS] ();
  spm_stat_if stat_if ();

  spm_addr_map addr_map_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_we_i    (req_we_i),
    .req_addr_i  (spm_pkg::spm_addr_u'(req_addr_i)),
    .req_wdata_i (req_wdata_i),
    .req_be_i    (req_be_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_rdata_o (rsp_rdata_o),
    .bank        (bank_if),
    .stat        (stat_if)
  );

  spm_cfg_regs cfg_regs_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_valid_i (cfg_valid_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .stat        (stat_if)
  );

  // One SRAM per bank
  for (genvar b = 0; b < `SPM_NUM_BANKS; b++) begin : gen_bank
    sram sram_i (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .bank    (bank_if[b])
    );
  end

endmodule

/* test/tb_spm.sv */
// Scratchpad memory testbench
`include "spm_consts.svh"

module tb_spm;
  timeunit 1ns;
  timeprecision 1ps;

  typedef enum logic [2:0] {K_CFG_WR, K_CFG_RD, K_MEM_WR, K_MEM_RD, K_STREAM} kind_e;

  typedef struct packed {
    logic [8*12-1:0]        name;
    kind_e                  kind;
    logic [`SPM_ADDR_W-1:0] addr;
    logic [`SPM_DATA_W-1:0] data;
    logic [`SPM_STRB_W-1:0] be;
    logic                   check;
  } step_t;

  localparam int NUM_STEPS   = 36;
  localparam int RAND_LEN    = 48;
  localparam int CYCLE_LIMIT = 2 * NUM_STEPS + RAND_LEN + 50;

  // Interleaved writes are read back in contiguous mode at the same physical word
  localparam step_t STEPS [NUM_STEPS] = '{
    '{"rst_mode",    K_CFG_RD, 10'h000, 32'h0000_0000, 4'h0, 1'b1},
    '{"rst_cnt0",    K_CFG_RD, 10'h001, 32'h0000_0000, 4'h0, 1'b1},
    '{"rst_cnt1",    K_CFG_RD, 10'h002, 32'h0000_0000, 4'h0, 1'b1},
    '{"rst_cnt2",    K_CFG_RD, 10'h003, 32'h0000_0000, 4'h0, 1'b1},
    '{"rst_cnt3",    K_CFG_RD, 10'h004, 32'h0000_0000, 4'h0, 1'b1},
    '{"wr_full",     K_MEM_WR, 10'h005, 32'ha5a5_1234, 4'hf, 1'b1},
    '{"rd_full",     K_MEM_RD, 10'h005, 32'h0000_0000, 4'h0, 1'b1},
    '{"wr_byte",     K_MEM_WR, 10'h005, 32'hffff_cdff, 4'h2, 1'b1},
    '{"rd_byte",     K_MEM_RD, 10'h005, 32'h0000_0000, 4'h0, 1'b1},
    '{"il_wr_a",     K_MEM_WR, 10'h100, 32'h1111_1111, 4'hf, 1'b1},
    '{"il_wr_b",     K_MEM_WR, 10'h101, 32'h2222_2222, 4'hf, 1'b1},
    '{"il_wr_c",     K_MEM_WR, 10'h040, 32'h3333_3333, 4'hf, 1'b1},
    '{"il_wr_d",     K_MEM_WR, 10'h002, 32'h4444_4444, 4'h3, 1'b1},
    '{"mode_ct",     K_CFG_WR, 10'h000, 32'h0000_0001, 4'h0, 1'b0},
    '{"rd_mode_ct",  K_CFG_RD, 10'h000, 32'h0000_0000, 4'h0, 1'b1},
    '{"ct_rd_a",     K_MEM_RD, 10'h040, 32'h0000_0000, 4'h0, 1'b1},
    '{"ct_rd_b",     K_MEM_RD, 10'h140, 32'h0000_0000, 4'h0, 1'b1},
    '{"ct_rd_c",     K_MEM_RD, 10'h010, 32'h0000_0000, 4'h0, 1'b1},
    '{"ct_rd_d",     K_MEM_RD, 10'h200, 32'h0000_0000, 4'h0, 1'b1},
    '{"ct_wr_top",   K_MEM_WR, 10'h3ff, 32'h5555_5555, 4'hf, 1'b1},
    '{"ct_rd_top",   K_MEM_RD, 10'h3ff, 32'h0000_0000, 4'h0, 1'b1},
    '{"mode_il",     K_CFG_WR, 10'h000, 32'h0000_0000, 4'h0, 1'b0},
    '{"il_rd_a",     K_MEM_RD, 10'h100, 32'h0000_0000, 4'h0, 1'b1},
    '{"il_rd_b",     K_MEM_RD, 10'h101, 32'h0000_0000, 4'h0, 1'b1},
    '{"il_rd_d",     K_MEM_RD, 10'h002, 32'h0000_0000, 4'h0, 1'b1},
    '{"il_rd_top",   K_MEM_RD, 10'h3ff, 32'h0000_0000, 4'h0, 1'b1},
    '{"stream",      K_STREAM, 10'h000, 32'h0000_0000, 4'h0, 1'b1},
    '{"cnt0",        K_CFG_RD, 10'h001, 32'h0000_0000, 4'h0, 1'b1},
    '{"cnt1",        K_CFG_RD, 10'h002, 32'h0000_0000, 4'h0, 1'b1},
    '{"cnt2",        K_CFG_RD, 10'h003, 32'h0000_0000, 4'h0, 1'b1},
    '{"cnt3",        K_CFG_RD, 10'h004, 32'h0000_0000, 4'h0, 1'b1},
    '{"clr_cnt1",    K_CFG_WR, 10'h002, 32'hdead_beef, 4'h0, 1'b0},
    '{"rd_cnt1",     K_CFG_RD, 10'h002, 32'h0000_0000, 4'h0, 1'b1},
    '{"clr_cnt0",    K_CFG_WR, 10'h001, 32'h0000_0000, 4'h0, 1'b0},
    '{"rd_cnt0",     K_CFG_RD, 10'h001, 32'h0000_0000, 4'h0, 1'b1},
    '{"rd_unmapped", K_CFG_RD, 10'h007, 32'h0000_0000, 4'h0, 1'b1}
  };

  logic                       clk;
  logic                       rst_n;
  logic                       req_valid;
  logic                       req_ready;
  logic                       req_we;
  logic [`SPM_ADDR_W-1:0]     req_addr;
  logic [`SPM_DATA_W-1:0]     req_wdata;
  logic [`SPM_STRB_W-1:0]     req_be;
  logic                       rsp_valid;
  logic [`SPM_DATA_W-1:0]     rsp_rdata;
  logic                       cfg_valid;
  logic                       cfg_we;
  logic [`SPM_CFG_ADDR_W-1:0] cfg_addr;
  logic [`SPM_DATA_W-1:0]     cfg_wdata;
  logic [`SPM_DATA_W-1:0]     cfg_rdata;

  // Shadow model indexed by bank then row
  logic [`SPM_DATA_W-1:0] shadow [`SPM_NUM_BANKS*`SPM_ROWS];
  logic [`SPM_STRB_W-1:0] known [`SPM_NUM_BANKS*`SPM_ROWS];
  logic [`SPM_CNT_W-1:0]  cnt_exp [`SPM_NUM_BANKS];
  logic                   mode_exp;
  logic                   stall_exp;

  // Response expected in the next cycle
  logic                   rsp_pend;
  logic [`SPM_DATA_W-1:0] rsp_exp;
  logic [`SPM_DATA_W-1:0] rsp_mask;
  string                  rsp_name;
  logic                   mon_accepted;
  logic [`SPM_ADDR_W-1:0] mon_idx;

  string  cur_name;
  logic   cur_check;
  int     errors;
  int     tests_passed;
  int     tests_failed;
  int     cycles;
  integer seed;

  spm_top dut_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_we_i    (req_we),
    .req_addr_i  (req_addr),
    .req_wdata_i (req_wdata),
    .req_be_i    (req_be),
    .rsp_valid_o (rsp_valid),
    .rsp_rdata_o (rsp_rdata),
    .cfg_valid_i (cfg_valid),
    .cfg_we_i    (cfg_we),
    .cfg_addr_i  (cfg_addr),
    .cfg_wdata_i (cfg_wdata),
    .cfg_rdata_o (cfg_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Interleaved puts the bank in the low bits and contiguous in the high bits
  function automatic logic [`SPM_ADDR_W-1:0] phys_index(input logic [`SPM_ADDR_W-1:0] addr,
                                                        input logic mode);
    if (mode) begin
      return addr;
    end
    return {addr[1:0], addr[9:2]};
  endfunction

  function automatic logic [`SPM_DATA_W-1:0] byte_mask(input logic [`SPM_STRB_W-1:0] k);
    logic [`SPM_DATA_W-1:0] m;
    for (int b = 0; b < `SPM_STRB_W; b++) begin
      m[b*8 +: 8] = {8{k[b]}};
    end
    return m;
  endfunction

  function automatic logic [`SPM_DATA_W-1:0] cfg_model_value(input logic [2:0] a);
    case (a)
      3'd0:    return {31'd0, mode_exp};
      3'd1:    return {16'd0, cnt_exp[0]};
      3'd2:    return {16'd0, cnt_exp[1]};
      3'd3:    return {16'd0, cnt_exp[2]};
      3'd4:    return {16'd0, cnt_exp[3]};
      default: return 32'd0;
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s expected %08h actual %08h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic set_idle();
    req_valid = 1'b0;
    req_we    = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    req_be    = '0;
    cfg_valid = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
  endtask

  // Checks responses, ready and config reads, then advances the model
  always @(negedge clk) begin
    if (rst_n) begin
      compare_value({cur_name, " ready"}, 32'(!stall_exp), 32'(req_ready));
      if (rsp_pend && !rsp_valid) begin
        $display("No response arrived for %s", rsp_name);
        errors++;
      end else if (!rsp_pend && rsp_valid) begin
        $display("Response arrived with no request outstanding during %s", cur_name);
        errors++;
      end else if (rsp_pend) begin
        compare_value(rsp_name, rsp_exp & rsp_mask, rsp_rdata & rsp_mask);
      end
      if (cfg_valid && !cfg_we && cur_check) begin
        compare_value(cur_name, cfg_model_value(cfg_addr), cfg_rdata);
      end

      mon_accepted = req_valid && req_ready;
      rsp_pend     = mon_accepted;
      if (mon_accepted) begin
        mon_idx  = phys_index(req_addr, mode_exp);
        rsp_name = cur_name;
        if (req_we) begin
          for (int b = 0; b < `SPM_STRB_W; b++) begin
            if (req_be[b]) begin
              shadow[mon_idx][b*8 +: 8] = req_wdata[b*8 +: 8];
              known[mon_idx][b] = 1'b1;
            end
          end
          rsp_exp  = '0;
          rsp_mask = '1;
        end else begin
          rsp_exp  = shadow[mon_idx];
          rsp_mask = cur_check ? byte_mask(known[mon_idx]) : '0;
        end
      end

      // A clear beats an increment in the same cycle
      for (int b = 0; b < `SPM_NUM_BANKS; b++) begin
        if (cfg_valid && cfg_we && (cfg_addr == 3'(b + 1))) begin
          cnt_exp[b] = '0;
        end else if (mon_accepted && (mon_idx[9:8] == 2'(b)) && (cnt_exp[b] != '1)) begin
          cnt_exp[b] = cnt_exp[b] + 16'd1;
        end
      end

      stall_exp = cfg_valid && cfg_we && (cfg_addr == 3'd0);
      if (stall_exp) begin
        mode_exp = cfg_wdata[0];
      end
    end
  end

  task automatic cfg_step(input logic we, input logic [2:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    set_idle();
    cfg_valid = 1'b1;
    cfg_we    = we;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    #1;
  endtask

  // Holds the request until it is taken, then waits for its response
  task automatic mem_step(input logic we, input logic [`SPM_ADDR_W-1:0] addr,
                          input logic [31:0] data, input logic [3:0] be);
    @(posedge clk);
    #1;
    set_idle();
    req_valid = 1'b1;
    req_we    = we;
    req_addr  = addr;
    req_wdata = data;
    req_be    = be;
    do begin
      @(negedge clk);
      #1;
    end while (!mon_accepted);
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    @(negedge clk);
    #1;
  endtask

  // Back-to-back traffic over a small window with writes first to seed the data
  task automatic stream_burst();
    logic [31:0] rnd;
    for (int i = 0; i < RAND_LEN; i++) begin
      @(posedge clk);
      #1;
      rnd       = $random(seed);
      req_valid = 1'b1;
      req_we    = (i < 16) || (rnd[31:30] == 2'b00);
      req_addr  = {6'd0, rnd[3:0]};
      req_wdata = $random(seed);
      req_be    = (rnd[8:5] == 4'd0) ? 4'hf : rnd[8:5];
    end
    @(posedge clk);
    #1;
    set_idle();
    @(negedge clk);
    #1;
  endtask

  task automatic run_step(input step_t s);
    int errors_before;
    errors_before = errors;
    cur_name      = string'(s.name);
    cur_check     = s.check;
    case (s.kind)
      K_CFG_WR: cfg_step(1'b1, s.addr[2:0], s.data);
      K_CFG_RD: cfg_step(1'b0, s.addr[2:0], s.data);
      K_MEM_WR: mem_step(1'b1, s.addr, s.data, s.be);
      K_MEM_RD: mem_step(1'b0, s.addr, s.data, s.be);
      default:  stream_burst();
    endcase
    if (errors == errors_before) begin
      tests_passed++;
      $display("%-12s ok", cur_name);
    end else begin
      tests_failed++;
      $display("%-12s FAIL", cur_name);
    end
  endtask

  always @(posedge clk) begin
    cycles++;
  end

  initial begin
    wait (cycles > CYCLE_LIMIT);
    $display("Timeout, run still busy after %0d cycles", CYCLE_LIMIT);
    $display("Regression failed");
    $finish;
  end

  initial begin
    seed         = 32'h54675485;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycles       = 0;
    mode_exp     = 1'b0;
    stall_exp    = 1'b0;
    rsp_pend     = 1'b0;
    rsp_exp      = '0;
    rsp_mask     = '0;
    rsp_name     = "reset";
    mon_accepted = 1'b0;
    mon_idx      = '0;
    cur_name     = "reset";
    cur_check    = 1'b0;
    for (int i = 0; i < `SPM_NUM_BANKS*`SPM_ROWS; i++) begin
      shadow[i] = '0;
      known[i]  = '0;
    end
    for (int b = 0; b < `SPM_NUM_BANKS; b++) begin
      cnt_exp[b] = '0;
    end
    rst_n = 1'b0;
    set_idle();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    @(negedge clk);
    #1;
    compare_value("reset_ready", 32'd1, 32'(req_ready));
    compare_value("reset_rsp", 32'd0, 32'(rsp_valid));
    if (errors == 0) begin
      tests_passed++;
      $display("%-12s ok", "reset");
    end else begin
      tests_failed++;
      $display("%-12s FAIL", "reset");
    end

    for (int i = 0; i < NUM_STEPS; i++) begin
      run_step(STEPS[i]);
    end

    $display("Tests: %0d ok, %0d with errors, %0d errors in total",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+src
src/spm_pkg.sv
src/spm_bank_if.sv
src/spm_stat_if.sv
src/sram.sv
src/spm_addr_map.sv
src/spm_cfg_regs.sv
src/spm_top.sv
test/tb_spm.sv

/* run.sh */
#!/bin/sh
# Build and run the scratchpad memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_spm -o tb_spm

./obj_dir/tb_spm > sim.log 2>&1
cat sim.log

if grep -q "Regression passed" sim.log; then
  exit 0
fi
echo "Simulation log has no pass line"
exit 1
